//--- flist.f
rtl/tile_cfg_pkg.sv
rtl/tile_pkt_pkg.sv
rtl/mem_bank.sv
rtl/bank_crossbar.sv
rtl/pkt_fifo.sv
rtl/remote_store_tx.sv
rtl/reservation_tracker.sv
rtl/tile_mem_top.sv
tests/tile_tb.sv

//--- rtl/bank_crossbar.sv
`default_nettype none

module bank_crossbar
  #(parameter int num_banks_p  = 4
   ,parameter int bank_words_p = 64
   )
   (input  logic                                          clk_i
   ,input  logic                                          rst_n_i
   // port 0 imem, port 1 network, port 2 dmem
   ,input  tile_pkt_pkg::xbar_req_t [2:0]                 req_i
   ,output logic [2:0]                                    yumi_o
   ,output logic [2:0]                                    rv_o
   ,output logic [2:0][tile_cfg_pkg::data_width_c-1:0]    rdata_o
   );

   import tile_cfg_pkg::*;
   import tile_pkt_pkg::*;

   // low word-address bits pick the bank, next bits the row
   localparam int bank_bits_lp = $clog2(num_banks_p);
   localparam int idx_bits_lp  = $clog2(bank_words_p);

   // per-bank one-hot grant
   logic [num_banks_p-1:0][2:0]              grant;
   // per-bank one-hot port that read last cycle
   logic [num_banks_p-1:0][2:0]              rd_sel;
   logic [num_banks_p-1:0][data_width_c-1:0] bank_rdata;

   for (genvar b = 0; b < num_banks_p; b++)
   begin : g_bank
      logic [2:0] hit;
      logic [2:0] gnt;
      logic [2:0] rd_sel_r;
      xbar_req_t  sel_req;

      always_comb
      begin
         for (int p = 0; p < 3; p++)
         begin
            hit[p] = req_i[p].valid
                     && (req_i[p].addr[bank_bits_lp-1:0] == bank_bits_lp'(b));
         end
         // fixed priority, dmem then network then imem
         gnt     = 3'b000;
         sel_req = req_i[0];
         if (hit[2])
         begin
            gnt     = 3'b100;
            sel_req = req_i[2];
         end
         else if (hit[1])
         begin
            gnt     = 3'b010;
            sel_req = req_i[1];
         end
         else if (hit[0])
         begin
            gnt = 3'b001;
         end
      end

      mem_bank #(.words_p(bank_words_p)) mem_bank_inst
        (.clk_i   (clk_i)
        ,.en_i    (|gnt)
        ,.we_i    (sel_req.write)
        ,.addr_i  (sel_req.addr[bank_bits_lp +: idx_bits_lp])
        ,.wdata_i (sel_req.data)
        ,.mask_i  (sel_req.mask)
        ,.rdata_o (bank_rdata[b])
        );

      // remember who read, so the data goes back to that port
      always_ff @(posedge clk_i or negedge rst_n_i)
      begin
         if (!rst_n_i)
            rd_sel_r <= 3'b000;
         else
            rd_sel_r <= gnt & {3{~sel_req.write}};
      end

      assign grant[b]  = gnt;
      assign rd_sel[b] = rd_sel_r;

      // a bank serves exactly one of the ports that hit it
      a_one_grant : assert property (@(posedge clk_i) disable iff (!rst_n_i)
         (|hit) |-> $onehot(yumi_o & hit));
   end

   // a port only ever hits one bank, so plain OR merges the banks
   always_comb
   begin
      yumi_o  = '0;
      rv_o    = '0;
      rdata_o = '0;
      for (int b = 0; b < num_banks_p; b++)
      begin
         yumi_o = yumi_o | grant[b];
         rv_o   = rv_o | rd_sel[b];
         for (int p = 0; p < 3; p++)
         begin
            if (rd_sel[b][p])
               rdata_o[p] = rdata_o[p] | bank_rdata[b];
         end
      end
   end

   // every accepted read returns exactly one cycle later
   for (genvar p = 0; p < 3; p++)
   begin : g_port_chk
      a_read_return : assert property (@(posedge clk_i) disable iff (!rst_n_i)
         (yumi_o[p] && !req_i[p].write) |=> rv_o[p]);
   end

endmodule

`default_nettype wire

//--- rtl/mem_bank.sv
`default_nettype none

module mem_bank
  #(parameter int words_p = 64
   ,localparam int addr_w_lp = $clog2(words_p)
   )
   (input  logic                                   clk_i
   ,input  logic                                   en_i
   ,input  logic                                   we_i
   ,input  logic [addr_w_lp-1:0]                   addr_i
   ,input  logic [tile_cfg_pkg::data_width_c-1:0]  wdata_i
   ,input  logic [tile_cfg_pkg::mask_width_c-1:0]  mask_i
   ,output logic [tile_cfg_pkg::data_width_c-1:0]  rdata_o
   );

   import tile_cfg_pkg::*;

   // storage, contents undefined until written
   logic [data_width_c-1:0] mem_r [words_p];

   always_ff @(posedge clk_i)
   begin
      if (en_i)
      begin
         if (we_i)
         begin
            // only the masked bytes change
            for (int b = 0; b < mask_width_c; b++)
            begin
               if (mask_i[b])
                  mem_r[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
         else
         begin
            // registered read, valid the cycle after the grant
            rdata_o <= mem_r[addr_i];
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/pkt_fifo.sv
`default_nettype none

module pkt_fifo
  #(parameter type payload_t = logic [7:0]
   ,parameter int  depth_p   = 2
   )
   (input  logic     clk_i
   ,input  logic     rst_n_i
   // producer side, valid/ready
   ,input  logic     v_i
   ,input  payload_t data_i
   ,output logic     ready_o
   // consumer side, valid/yumi
   ,output logic     v_o
   ,output payload_t data_o
   ,input  logic     yumi_i
   );

   localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
   localparam int cnt_w_lp = $clog2(depth_p + 1);

   payload_t            mem_r [depth_p];
   logic [ptr_w_lp-1:0] wr_ptr_r;
   logic [ptr_w_lp-1:0] rd_ptr_r;
   logic [cnt_w_lp-1:0] count_r;
   logic                push;

   assign ready_o = (count_r != cnt_w_lp'(depth_p));
   assign v_o     = (count_r != '0);
   assign data_o  = mem_r[rd_ptr_r];
   assign push    = v_i && ready_o;

   // payload slots need no reset
   always_ff @(posedge clk_i)
   begin
      if (push)
         mem_r[wr_ptr_r] <= data_i;
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         // pointers wrap at depth, not at a power of two
         if (push)
            wr_ptr_r <= (wr_ptr_r == ptr_w_lp'(depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
         if (yumi_i)
            rd_ptr_r <= (rd_ptr_r == ptr_w_lp'(depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
         if (push && !yumi_i)
            count_r <= count_r + 1'b1;
         else if (!push && yumi_i)
            count_r <= count_r - 1'b1;
      end
   end

   // consumer must not take from an empty buffer
   a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      yumi_i |-> v_o);
   // pointer gap tracks occupancy so a full buffer was never overrun
   a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (count_r <= cnt_w_lp'(depth_p))
      && ((int'(wr_ptr_r) + depth_p - int'(rd_ptr_r)) % depth_p
          == int'(count_r) % depth_p));

endmodule

`default_nettype wire

//--- rtl/remote_store_tx.sv
`default_nettype none

module remote_store_tx
  #(parameter int max_credits_p = 4
   )
   (input  logic                   clk_i
   ,input  logic                   rst_n_i
   ,input  tile_pkt_pkg::mem_req_t dmem_req_i
   ,output logic                   remote_yumi_o
   ,input  tile_pkt_pkg::coord_t   my_x_i
   ,input  tile_pkt_pkg::coord_t   my_y_i
   // one credit back per strobe
   ,input  logic                   credit_return_i
   ,output logic                   pkt_v_o
   ,output tile_pkt_pkg::net_pkt_t pkt_o
   ,input  logic                   pkt_ready_i
   ,output logic                   outstanding_o
   );

   localparam int cnt_w_lp = $clog2(max_credits_p + 1);

   logic [cnt_w_lp-1:0] credits_r;
   logic                remote;
   logic                accept;

   // bit 31 marks an address outside this tile
   assign remote = dmem_req_i.valid && dmem_req_i.addr[31];
   // hold off when out of credits or the outbound buffer is full
   assign accept = remote && (credits_r != '0) && pkt_ready_i;

   assign remote_yumi_o = accept;
   assign pkt_v_o       = accept;

   // destination and word address sliced out of the byte address
   assign pkt_o.x    = dmem_req_i.addr[30:27];
   assign pkt_o.y    = dmem_req_i.addr[26:23];
   assign pkt_o.addr = dmem_req_i.addr[17:2];
   assign pkt_o.data = dmem_req_i.data;
   assign pkt_o.mask = dmem_req_i.mask;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         credits_r <= cnt_w_lp'(max_credits_p);
      else if (accept && !credit_return_i)
         credits_r <= credits_r - 1'b1;
      else if (!accept && credit_return_i)
         credits_r <= credits_r + 1'b1;
   end

   // any credit missing means a store is still in flight
   assign outstanding_o = (credits_r < cnt_w_lp'(max_credits_p));

   // more returns than sends would mean a lost or duplicated credit
   a_no_extra_credit : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      credit_return_i |-> (credits_r != cnt_w_lp'(max_credits_p)));

   // tile coordinates are strapped and hold still once out of reset
   a_coord_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $stable({my_x_i, my_y_i}));

endmodule

`default_nettype wire

//--- rtl/reservation_tracker.sv
`default_nettype none

module reservation_tracker
   (input  logic                    clk_i
   ,input  logic                    rst_n_i
   ,input  tile_pkt_pkg::mem_req_t  dmem_req_i
   ,input  logic                    dmem_yumi_i
   // inbound store granted to memory this cycle
   ,input  tile_pkt_pkg::xbar_req_t net_wr_i
   ,output logic                    reservation_o
   );

   import tile_pkt_pkg::*;

   waddr_t resv_addr_r;
   logic   set;
   logic   clr;

   // accepted reserved load to local memory
   assign set = dmem_req_i.valid && dmem_req_i.reserve && !dmem_req_i.write
                && !dmem_req_i.addr[31] && dmem_yumi_i;
   // remote store hitting the reserved word
   assign clr = reservation_o && net_wr_i.valid && (net_wr_i.addr == resv_addr_r);

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         reservation_o <= 1'b0;
      else if (set)
         // set beats clear when both land together
         reservation_o <= 1'b1;
      else if (clr)
         reservation_o <= 1'b0;
   end

   // word address only, byte offset dropped
   always_ff @(posedge clk_i)
   begin
      if (set)
         resv_addr_r <= dmem_req_i.addr[17:2];
   end

endmodule

`default_nettype wire

//--- rtl/tile_cfg_pkg.sv
`default_nettype none

package tile_cfg_pkg;

   // geometry of the banked local memory
   localparam int num_banks_c = 4;
   // words held by one bank
   localparam int bank_words_c = 64;

   // remote stores allowed in flight before the data port stalls
   localparam int max_credits_c = 4;

   // entries in each packet FIFO on the network side
   localparam int fifo_depth_c = 2;

   // word and byte-mask widths of the core and the network
   localparam int data_width_c = 32;
   localparam int mask_width_c = 4;

endpackage

`default_nettype wire

//--- rtl/tile_mem_top.sv
`default_nettype none

module tile_mem_top
  #(parameter int num_banks_p   = tile_cfg_pkg::num_banks_c
   ,parameter int bank_words_p  = tile_cfg_pkg::bank_words_c
   ,parameter int max_credits_p = tile_cfg_pkg::max_credits_c
   ,parameter int fifo_depth_p  = tile_cfg_pkg::fifo_depth_c
   )
   (input  logic                                  clk_i
   ,input  logic                                  rst_n_i
   ,input  tile_pkt_pkg::coord_t                  my_x_i
   ,input  tile_pkt_pkg::coord_t                  my_y_i
   // instruction port, reads only
   ,input  tile_pkt_pkg::mem_req_t                imem_req_i
   ,output logic                                  imem_yumi_o
   ,output logic                                  imem_rv_o
   ,output logic [tile_cfg_pkg::data_width_c-1:0] imem_rdata_o
   // data port, local or remote by bit 31
   ,input  tile_pkt_pkg::mem_req_t                dmem_req_i
   ,output logic                                  dmem_yumi_o
   ,output logic                                  dmem_rv_o
   ,output logic [tile_cfg_pkg::data_width_c-1:0] dmem_rdata_o
   // inbound link
   ,input  logic                                  net_in_v_i
   ,input  tile_pkt_pkg::net_pkt_t                net_in_pkt_i
   ,output logic                                  net_in_ready_o
   // outbound link
   ,output logic                                  net_out_v_o
   ,output tile_pkt_pkg::net_pkt_t                net_out_pkt_o
   ,input  logic                                  net_out_ready_i
   ,input  logic                                  credit_return_i
   ,output logic                                  outstanding_o
   ,output logic                                  reservation_o
   );

   import tile_cfg_pkg::*;
   import tile_pkt_pkg::*;

   xbar_req_t [2:0]                   xbar_req;
   logic [2:0]                        xbar_yumi;
   logic [2:0]                        xbar_rv;
   logic [2:0][data_width_c-1:0]      xbar_rdata;
   xbar_req_t                         net_wr;
   net_pkt_t                          in_pkt;
   net_pkt_t                          tx_pkt;
   logic                              in_v;
   logic                              in_mine;
   logic                              in_yumi;
   logic                              tx_v;
   logic                              tx_ready;
   logic                              remote_yumi;

   pkt_fifo #(.payload_t(net_pkt_t), .depth_p(fifo_depth_p)) in_fifo_inst
     (.clk_i   (clk_i)
     ,.rst_n_i (rst_n_i)
     ,.v_i     (net_in_v_i)
     ,.data_i  (net_in_pkt_i)
     ,.ready_o (net_in_ready_o)
     ,.v_o     (in_v)
     ,.data_o  (in_pkt)
     ,.yumi_i  (in_yumi)
     );

   // packets for another tile are dropped straight from the head
   assign in_mine = (in_pkt.x == my_x_i) && (in_pkt.y == my_y_i);
   assign in_yumi = (in_v && !in_mine) || xbar_yumi[1];

   always_comb
   begin
      // port 0, imem never writes
      xbar_req[0].valid = imem_req_i.valid;
      xbar_req[0].write = 1'b0;
      xbar_req[0].addr  = imem_req_i.addr[17:2];
      xbar_req[0].data  = imem_req_i.data;
      xbar_req[0].mask  = imem_req_i.mask;
      // port 1, network always writes
      xbar_req[1].valid = in_v && in_mine;
      xbar_req[1].write = 1'b1;
      xbar_req[1].addr  = in_pkt.addr;
      xbar_req[1].data  = in_pkt.data;
      xbar_req[1].mask  = in_pkt.mask;
      // port 2, dmem only when the address is local
      xbar_req[2].valid = dmem_req_i.valid && !dmem_req_i.addr[31];
      xbar_req[2].write = dmem_req_i.write;
      xbar_req[2].addr  = dmem_req_i.addr[17:2];
      xbar_req[2].data  = dmem_req_i.data;
      xbar_req[2].mask  = dmem_req_i.mask;
   end

   bank_crossbar #(.num_banks_p(num_banks_p), .bank_words_p(bank_words_p)) xbar_inst
     (.clk_i   (clk_i)
     ,.rst_n_i (rst_n_i)
     ,.req_i   (xbar_req)
     ,.yumi_o  (xbar_yumi)
     ,.rv_o    (xbar_rv)
     ,.rdata_o (xbar_rdata)
     );

   remote_store_tx #(.max_credits_p(max_credits_p)) tx_inst
     (.clk_i           (clk_i)
     ,.rst_n_i         (rst_n_i)
     ,.dmem_req_i      (dmem_req_i)
     ,.remote_yumi_o   (remote_yumi)
     ,.my_x_i          (my_x_i)
     ,.my_y_i          (my_y_i)
     ,.credit_return_i (credit_return_i)
     ,.pkt_v_o         (tx_v)
     ,.pkt_o           (tx_pkt)
     ,.pkt_ready_i     (tx_ready)
     ,.outstanding_o   (outstanding_o)
     );

   // registers the packet, so the link sees it one cycle after yumi
   pkt_fifo #(.payload_t(net_pkt_t), .depth_p(fifo_depth_p)) out_fifo_inst
     (.clk_i   (clk_i)
     ,.rst_n_i (rst_n_i)
     ,.v_i     (tx_v)
     ,.data_i  (tx_pkt)
     ,.ready_o (tx_ready)
     ,.v_o     (net_out_v_o)
     ,.data_o  (net_out_pkt_o)
     ,.yumi_i  (net_out_v_o && net_out_ready_i)
     );

   // inbound store that reached memory this cycle
   always_comb
   begin
      net_wr       = xbar_req[1];
      net_wr.valid = xbar_yumi[1];
   end

   reservation_tracker resv_inst
     (.clk_i         (clk_i)
     ,.rst_n_i       (rst_n_i)
     ,.dmem_req_i    (dmem_req_i)
     ,.dmem_yumi_i   (dmem_yumi_o)
     ,.net_wr_i      (net_wr)
     ,.reservation_o (reservation_o)
     );

   assign imem_yumi_o  = xbar_yumi[0];
   assign imem_rv_o    = xbar_rv[0];
   assign imem_rdata_o = xbar_rdata[0];
   // either the banks or the transmitter takes the data request
   assign dmem_yumi_o  = xbar_yumi[2] | remote_yumi;
   assign dmem_rv_o    = xbar_rv[2];
   assign dmem_rdata_o = xbar_rdata[2];

endmodule

`default_nettype wire

//--- rtl/tile_pkt_pkg.sv
`default_nettype none

package tile_pkt_pkg;

   // one mesh coordinate
   typedef logic [3:0] coord_t;

   // word address as carried on the network and into the crossbar
   typedef logic [15:0] waddr_t;

   // request from a core port, byte addressed
   typedef struct packed {
      logic                                   valid;
      logic                                   write;
      // load-reserved marker, data port only
      logic                                   reserve;
      logic [31:0]                            addr;
      logic [tile_cfg_pkg::data_width_c-1:0]  data;
      logic [tile_cfg_pkg::mask_width_c-1:0]  mask;
   } mem_req_t;

   // request on one crossbar port, already word addressed
   typedef struct packed {
      logic                                   valid;
      logic                                   write;
      waddr_t                                 addr;
      logic [tile_cfg_pkg::data_width_c-1:0]  data;
      logic [tile_cfg_pkg::mask_width_c-1:0]  mask;
   } xbar_req_t;

   // remote store as it travels between tiles
   typedef struct packed {
      coord_t                                 x;
      coord_t                                 y;
      waddr_t                                 addr;
      logic [tile_cfg_pkg::data_width_c-1:0]  data;
      logic [tile_cfg_pkg::mask_width_c-1:0]  mask;
   } net_pkt_t;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the tile memory testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tile_tb -o tile_sim
if [ $? -ne 0 ]; then
   echo "build step failed"
   exit 1
fi

./obj_dir/tile_sim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$LOG"
   echo "simulation returned a failing status"
   exit 1
fi

cat "$LOG"
if grep -q "Verification failed" "$LOG"; then
   exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0

//--- tests/tile_tb.sv
`default_nettype none

module tile_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import tile_cfg_pkg::*;
   import tile_pkt_pkg::*;

   localparam int max_wait_c = 100;
   localparam int fill_words_c = 32;
   localparam coord_t my_x_c = 4'd3;
   localparam coord_t my_y_c = 4'd5;

   logic clk_i = 1'b0;
   logic rst_n_i;
   mem_req_t imem_req, dmem_req;
   logic imem_yumi, imem_rv, dmem_yumi, dmem_rv;
   logic [data_width_c-1:0] imem_rdata, dmem_rdata;
   logic net_in_v, net_in_ready, net_out_v, net_out_ready;
   net_pkt_t net_in_pkt, net_out_pkt;
   logic credit_return, outstanding, reservation;

   // reference model state
   logic [data_width_c-1:0] model [256];
   logic [data_width_c-1:0] exp_d, exp_i;
   logic exp_d_rv, exp_i_rv, exp_out_v;
   net_pkt_t exp_pkt;
   int credits_m;
   // one-cycle check enables raised by the stimulus
   logic chk_reset, arb_same, arb_diff, chk_resv, exp_resv;
   int err_cnt = 0;
   int timeout_cnt = 0;

   always #2 clk_i = ~clk_i;

   tile_mem_top tile_mem_top_inst
     (.clk_i(clk_i), .rst_n_i(rst_n_i), .my_x_i(my_x_c), .my_y_i(my_y_c)
     ,.imem_req_i(imem_req), .imem_yumi_o(imem_yumi), .imem_rv_o(imem_rv)
     ,.imem_rdata_o(imem_rdata)
     ,.dmem_req_i(dmem_req), .dmem_yumi_o(dmem_yumi), .dmem_rv_o(dmem_rv)
     ,.dmem_rdata_o(dmem_rdata)
     ,.net_in_v_i(net_in_v), .net_in_pkt_i(net_in_pkt), .net_in_ready_o(net_in_ready)
     ,.net_out_v_o(net_out_v), .net_out_pkt_o(net_out_pkt)
     ,.net_out_ready_i(net_out_ready)
     ,.credit_return_i(credit_return), .outstanding_o(outstanding)
     ,.reservation_o(reservation)
     );

   // mirror every accepted access into the model
   always @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         exp_d_rv  <= 1'b0;
         exp_i_rv  <= 1'b0;
         exp_out_v <= 1'b0;
         credits_m <= max_credits_c;
      end
      else
      begin
         exp_d_rv <= dmem_yumi && !dmem_req.addr[31] && !dmem_req.write;
         exp_d    <= model[dmem_req.addr[9:2]];
         exp_i_rv <= imem_yumi;
         exp_i    <= model[imem_req.addr[9:2]];
         if (dmem_yumi && !dmem_req.addr[31] && dmem_req.write)
            for (int b = 0; b < 4; b++)
               if (dmem_req.mask[b])
                  model[dmem_req.addr[9:2]][8*b +: 8] <= dmem_req.data[8*b +: 8];
         // inbound store lands later, reads only follow after the drain
         if (net_in_v && net_in_ready && net_in_pkt.x == my_x_c && net_in_pkt.y == my_y_c)
            for (int b = 0; b < 4; b++)
               if (net_in_pkt.mask[b])
                  model[net_in_pkt.addr[7:0]][8*b +: 8] <= net_in_pkt.data[8*b +: 8];
         // remote packet fields straight from the address layout
         exp_out_v    <= dmem_yumi && dmem_req.addr[31];
         exp_pkt.x    <= dmem_req.addr[30:27];
         exp_pkt.y    <= dmem_req.addr[26:23];
         exp_pkt.addr <= dmem_req.addr[17:2];
         exp_pkt.data <= dmem_req.data;
         exp_pkt.mask <= dmem_req.mask;
         credits_m <= credits_m - int'(dmem_yumi && dmem_req.addr[31]) + int'(credit_return);
      end
   end

   a_reset : assert property (@(posedge clk_i) chk_reset |-> (!imem_yumi && !dmem_yumi
      && !imem_rv && !dmem_rv && !net_out_v && !reservation && !outstanding && net_in_ready))
      else begin
         $display("CHECK FAILED reset_state expected %b actual %b", 8'b0000_0001,
            $sampled({imem_yumi, dmem_yumi, imem_rv, dmem_rv, net_out_v, reservation,
            outstanding, net_in_ready}));
         err_cnt++;
      end
   a_d_rv : assert property (@(posedge clk_i) disable iff (!rst_n_i) dmem_rv == exp_d_rv)
      else begin
         $display("CHECK FAILED dmem_rv expected %b actual %b", $sampled(exp_d_rv),
            $sampled(dmem_rv));
         err_cnt++;
      end
   a_i_rv : assert property (@(posedge clk_i) disable iff (!rst_n_i) imem_rv == exp_i_rv)
      else begin
         $display("CHECK FAILED imem_rv expected %b actual %b", $sampled(exp_i_rv),
            $sampled(imem_rv));
         err_cnt++;
      end
   a_d_data : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      dmem_rv |-> dmem_rdata == exp_d)
      else begin
         $display("CHECK FAILED dmem_rdata expected %h actual %h", $sampled(exp_d),
            $sampled(dmem_rdata));
         err_cnt++;
      end
   a_i_data : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      imem_rv |-> imem_rdata == exp_i)
      else begin
         $display("CHECK FAILED imem_rdata expected %h actual %h", $sampled(exp_i),
            $sampled(imem_rdata));
         err_cnt++;
      end
   a_arb_same : assert property (@(posedge clk_i) arb_same |-> (dmem_yumi && !imem_yumi))
      else begin
         $display("CHECK FAILED arb_same_bank expected %b actual %b", 2'b10,
            $sampled({dmem_yumi, imem_yumi}));
         err_cnt++;
      end
   a_arb_diff : assert property (@(posedge clk_i) arb_diff |-> (dmem_yumi && imem_yumi))
      else begin
         $display("CHECK FAILED arb_diff_bank expected %b actual %b", 2'b11,
            $sampled({dmem_yumi, imem_yumi}));
         err_cnt++;
      end
   a_out_pkt : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      exp_out_v |-> (net_out_v && net_out_pkt == exp_pkt))
      else begin
         $display("CHECK FAILED remote_pkt expected %h actual %h", $sampled(exp_pkt),
            $sampled(net_out_pkt));
         err_cnt++;
      end
   a_no_credit : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (dmem_req.valid && dmem_req.addr[31] && credits_m == 0) |-> !dmem_yumi)
      else begin
         $display("CHECK FAILED credit_stall expected %b actual %b", 1'b0,
            $sampled(dmem_yumi));
         err_cnt++;
      end
   a_outstanding : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      outstanding == (credits_m < max_credits_c))
      else begin
         $display("CHECK FAILED outstanding expected %b actual %b",
            $sampled(credits_m < max_credits_c), $sampled(outstanding));
         err_cnt++;
      end
   a_resv : assert property (@(posedge clk_i) chk_resv |-> reservation == exp_resv)
      else begin
         $display("CHECK FAILED reservation expected %b actual %b", $sampled(exp_resv),
            $sampled(reservation));
         err_cnt++;
      end

   task automatic end_run();
      $display("checks done: %0d errors, %0d timeouts", err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   endtask

   task automatic report_timeout(input string what);
      $display("timeout while waiting for %s", what);
      timeout_cnt++;
   endtask

   task automatic dmem_access(input logic wr, input logic rsv, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] mask);
      int n;
      n = 0;
      dmem_req = '{valid: 1'b1, write: wr, reserve: rsv, addr: addr, data: data, mask: mask};
      #1;
      // yumi is looked at mid-cycle, clear of the drive time
      while (!dmem_yumi && n < max_wait_c)
      begin
         @(posedge clk_i);
         #2;
         n++;
      end
      if (!dmem_yumi)
         report_timeout("dmem_yumi_o");
      @(posedge clk_i);
      #1;
      dmem_req.valid = 1'b0;
   endtask

   task automatic imem_read(input logic [31:0] addr);
      int n;
      n = 0;
      imem_req = '{valid: 1'b1, write: 1'b0, reserve: 1'b0, addr: addr, data: '0, mask: '0};
      #1;
      while (!imem_yumi && n < max_wait_c)
      begin
         @(posedge clk_i);
         #2;
         n++;
      end
      if (!imem_yumi)
         report_timeout("imem_yumi_o");
      @(posedge clk_i);
      #1;
      imem_req.valid = 1'b0;
   endtask

   // push one packet in, then wait until the inbound FIFO has drained
   task automatic send_inbound(input coord_t x, input coord_t y, input logic [15:0] waddr,
                               input logic [31:0] data, input logic [3:0] mask);
      int n;
      n = 0;
      net_in_v   = 1'b1;
      net_in_pkt = '{x: x, y: y, addr: waddr, data: data, mask: mask};
      #1;
      while (!net_in_ready && n < max_wait_c)
      begin
         @(posedge clk_i);
         #2;
         n++;
      end
      if (!net_in_ready)
         report_timeout("net_in_ready_o");
      @(posedge clk_i);
      #1;
      net_in_v = 1'b0;
      n = 0;
      while (tile_mem_top_inst.in_v && n < max_wait_c)
      begin
         @(posedge clk_i);
         #1;
         n++;
      end
      if (tile_mem_top_inst.in_v)
         report_timeout("the inbound store to reach memory");
   endtask

   task automatic check_resv(input logic value);
      exp_resv = value;
      chk_resv = 1'b1;
      @(posedge clk_i);
      #1;
      chk_resv = 1'b0;
   endtask

   task automatic pulse_credit();
      credit_return = 1'b1;
      @(posedge clk_i);
      #1;
      credit_return = 1'b0;
   endtask

   function automatic logic [31:0] remote_addr(input coord_t x, input coord_t y,
                                               input logic [15:0] waddr);
      return {1'b1, x, y, 5'b0, waddr, 2'b00};
   endfunction

   initial
   begin
      logic [7:0] w;
      void'($urandom(32'hdeeeefa5));
      rst_n_i = 1'b0;
      imem_req = '0;
      dmem_req = '0;
      net_in_v = 1'b0;
      net_in_pkt = '0;
      net_out_ready = 1'b1;
      credit_return = 1'b0;
      {chk_reset, arb_same, arb_diff, chk_resv, exp_resv} = '0;
      repeat (8) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      chk_reset = 1'b1;
      @(posedge clk_i);
      #1;
      chk_reset = 1'b0;

      // fill with a pattern from every address bit
      for (int i = 0; i < fill_words_c; i++)
      begin
         w = 8'(i);
         dmem_access(1'b1, 1'b0, {22'b0, w, 2'b00}, {w, ~w, w ^ 8'h5a, w + 8'h11}, 4'hf);
      end
      // random masked writes with reads on both ports
      for (int i = 0; i < 40; i++)
      begin
         w = 8'($urandom % fill_words_c);
         dmem_access(1'b1, 1'b0, {22'b0, w, 2'b00}, $urandom, 4'($urandom));
         dmem_access(1'b0, 1'b0, {22'b0, w, 2'b00}, '0, '0);
         imem_read({22'b0, 8'($urandom % fill_words_c), 2'b00});
      end

      // same bank then different banks
      for (int i = 0; i < 8; i++)
      begin
         w = 8'($urandom % 24);
         arb_same = 1'b1;
         fork
            dmem_access(1'b0, 1'b0, {22'b0, w, 2'b00}, '0, '0);
            imem_read({22'b0, w + 8'd4, 2'b00});
            begin
               @(posedge clk_i);
               #1;
               arb_same = 1'b0;
            end
         join
         arb_diff = 1'b1;
         fork
            dmem_access(1'b0, 1'b0, {22'b0, w, 2'b00}, '0, '0);
            imem_read({22'b0, w + 8'd1, 2'b00});
            begin
               @(posedge clk_i);
               #1;
               arb_diff = 1'b0;
            end
         join
      end

      // inbound stores, one for this tile and one for another tile
      send_inbound(my_x_c, my_y_c, 16'd7, 32'hcafe_0007, 4'b0110);
      dmem_access(1'b0, 1'b0, {22'b0, 8'd7, 2'b00}, '0, '0);
      send_inbound(my_x_c + 4'd1, my_y_c, 16'd9, 32'hdead_0009, 4'hf);
      dmem_access(1'b0, 1'b0, {22'b0, 8'd9, 2'b00}, '0, '0);
      imem_read({22'b0, 8'd9, 2'b00});

      // remote stores until the credits run out
      for (int i = 0; i < max_credits_c; i++)
         dmem_access(1'b1, 1'b0, remote_addr(4'(i), 4'd2, 16'($urandom)), $urandom, 4'hf);
      dmem_req = '{valid: 1'b1, write: 1'b1, reserve: 1'b0,
                   addr: remote_addr(4'd1, 4'd1, 16'h0abc), data: 32'h1234_5678, mask: 4'hf};
      repeat (5) @(posedge clk_i);
      #1;
      pulse_credit();
      dmem_access(1'b1, 1'b0, remote_addr(4'd1, 4'd1, 16'h0abc), 32'h1234_5678, 4'hf);
      for (int i = 0; i < max_credits_c; i++)
         pulse_credit();

      // reservation set, survives another word, cleared by its own word
      dmem_access(1'b0, 1'b1, {22'b0, 8'd12, 2'b00}, '0, '0);
      check_resv(1'b1);
      send_inbound(my_x_c, my_y_c, 16'd13, 32'h0000_1313, 4'hf);
      check_resv(1'b1);
      send_inbound(my_x_c, my_y_c, 16'd12, 32'h0000_1212, 4'hf);
      check_resv(1'b0);
      dmem_access(1'b0, 1'b0, {22'b0, 8'd12, 2'b00}, '0, '0);

      repeat (4) @(posedge clk_i);
      end_run();
   end

endmodule

`default_nettype wire
